// File: common/tlb_settings.svh
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

// entry count, 8 and 32 also work
`define TLB_NUM 16

// page-size field values
`define TLB_PS_4K 6'd12
`define TLB_PS_2M 6'd21

// request latch contents after reset, access type is fetch
`define TLB_REQ_RST_VPN  20'h0
`define TLB_REQ_RST_ASID 8'h0
`define TLB_REQ_RST_PLV  2'd0

`endif

// File: common/tlb_entry_pkg.sv
`include "tlb_settings.svh"

package tlb_entry_pkg;

    // entry index
    typedef logic [$clog2(`TLB_NUM)-1:0] tlb_idx_t;

    // virtual page number and double-page number (vpn without its odd bit)
    typedef logic [19:0] vpn_t;
    typedef logic [18:0] vpn2_t;

    typedef logic [7:0] asid_t;

    // page size as log2 of the page bytes
    typedef logic [5:0] ps_t;

    typedef logic [19:0] pfn_t;

    // memory access type
    typedef logic [1:0] mat_t;

endpackage

// File: common/tlb_access_pkg.sv
package tlb_access_pkg;

    // 0 is the most privileged level
    typedef logic [1:0] plv_t;

    typedef enum logic [1:0] {
        MEM_FETCH = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_type_e;

    // one-hot exception code
    typedef logic [5:0] exc_t;

    localparam exc_t EXC_NONE   = 6'b000000;
    localparam exc_t EXC_REFILL = 6'b000001;
    localparam exc_t EXC_PIF    = 6'b000010;
    localparam exc_t EXC_PIL    = 6'b000100;
    localparam exc_t EXC_PIS    = 6'b001000;
    localparam exc_t EXC_PPI    = 6'b010000;
    // store to a clean page
    localparam exc_t EXC_PME    = 6'b100000;

endpackage

// File: hw/tlb/tlb_entries.sv
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_entries (
    input  logic                                 clk,
    input  logic                                 rst,
    // write port
    input  logic                                 we,
    input  tlb_entry_pkg::tlb_idx_t              w_index,
    input  tlb_entry_pkg::vpn2_t                 w_vpn2,
    input  tlb_entry_pkg::asid_t                 w_asid,
    input  tlb_entry_pkg::ps_t                   w_ps,
    input  logic                                 w_e,
    input  logic                                 w_g,
    input  tlb_entry_pkg::pfn_t                  w_pfn0,
    input  tlb_entry_pkg::mat_t                  w_mat0,
    input  tlb_access_pkg::plv_t                 w_plv0,
    input  logic                                 w_d0,
    input  logic                                 w_v0,
    input  tlb_entry_pkg::pfn_t                  w_pfn1,
    input  tlb_entry_pkg::mat_t                  w_mat1,
    input  tlb_access_pkg::plv_t                 w_plv1,
    input  logic                                 w_d1,
    input  logic                                 w_v1,
    // read port
    input  tlb_entry_pkg::tlb_idx_t              r_index,
    output tlb_entry_pkg::vpn2_t                 r_vpn2,
    output tlb_entry_pkg::asid_t                 r_asid,
    output tlb_entry_pkg::ps_t                   r_ps,
    output logic                                 r_e,
    output logic                                 r_g,
    output tlb_entry_pkg::pfn_t                  r_pfn0,
    output tlb_entry_pkg::mat_t                  r_mat0,
    output tlb_access_pkg::plv_t                 r_plv0,
    output logic                                 r_d0,
    output logic                                 r_v0,
    output tlb_entry_pkg::pfn_t                  r_pfn1,
    output tlb_entry_pkg::mat_t                  r_mat1,
    output tlb_access_pkg::plv_t                 r_plv1,
    output logic                                 r_d1,
    output logic                                 r_v1,
    // every entry, flat, for the associative compare
    output logic [`TLB_NUM-1:0]                  all_e,
    output logic [`TLB_NUM-1:0]                  all_g,
    output tlb_entry_pkg::asid_t [`TLB_NUM-1:0]  all_asid,
    output tlb_entry_pkg::vpn2_t [`TLB_NUM-1:0]  all_vpn2,
    output tlb_entry_pkg::ps_t [`TLB_NUM-1:0]    all_ps,
    output tlb_entry_pkg::pfn_t [`TLB_NUM-1:0]   all_pfn0,
    output tlb_entry_pkg::mat_t [`TLB_NUM-1:0]   all_mat0,
    output tlb_access_pkg::plv_t [`TLB_NUM-1:0]  all_plv0,
    output logic [`TLB_NUM-1:0]                  all_d0,
    output logic [`TLB_NUM-1:0]                  all_v0,
    output tlb_entry_pkg::pfn_t [`TLB_NUM-1:0]   all_pfn1,
    output tlb_entry_pkg::mat_t [`TLB_NUM-1:0]   all_mat1,
    output tlb_access_pkg::plv_t [`TLB_NUM-1:0]  all_plv1,
    output logic [`TLB_NUM-1:0]                  all_d1,
    output logic [`TLB_NUM-1:0]                  all_v1
);

    // only the enable bits come out of reset cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            all_e <= '0;
        end else if (we) begin
            all_e[w_index] <= w_e;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            all_g[w_index]    <= w_g;
            all_asid[w_index] <= w_asid;
            all_vpn2[w_index] <= w_vpn2;
            all_ps[w_index]   <= w_ps;
            all_pfn0[w_index] <= w_pfn0;
            all_mat0[w_index] <= w_mat0;
            all_plv0[w_index] <= w_plv0;
            all_d0[w_index]   <= w_d0;
            all_v0[w_index]   <= w_v0;
            all_pfn1[w_index] <= w_pfn1;
            all_mat1[w_index] <= w_mat1;
            all_plv1[w_index] <= w_plv1;
            all_d1[w_index]   <= w_d1;
            all_v1[w_index]   <= w_v1;
        end
    end

    // asynchronous indexed read
    assign r_vpn2 = all_vpn2[r_index];
    assign r_asid = all_asid[r_index];
    assign r_ps   = all_ps[r_index];
    assign r_e    = all_e[r_index];
    assign r_g    = all_g[r_index];
    assign r_pfn0 = all_pfn0[r_index];
    assign r_mat0 = all_mat0[r_index];
    assign r_plv0 = all_plv0[r_index];
    assign r_d0   = all_d0[r_index];
    assign r_v0   = all_v0[r_index];
    assign r_pfn1 = all_pfn1[r_index];
    assign r_mat1 = all_mat1[r_index];
    assign r_plv1 = all_plv1[r_index];
    assign r_d1   = all_d1[r_index];
    assign r_v1   = all_v1[r_index];

endmodule

// File: hw/tlb/tlb_match.sv
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_match (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 en,
    input  tlb_entry_pkg::vpn_t                  vpn,
    input  tlb_entry_pkg::asid_t                 asid,
    input  tlb_access_pkg::plv_t                 plv,
    input  tlb_access_pkg::mem_type_e            mem_type,
    input  logic [`TLB_NUM-1:0]                  all_e,
    input  logic [`TLB_NUM-1:0]                  all_g,
    input  tlb_entry_pkg::asid_t [`TLB_NUM-1:0]  all_asid,
    input  tlb_entry_pkg::vpn2_t [`TLB_NUM-1:0]  all_vpn2,
    input  tlb_entry_pkg::ps_t [`TLB_NUM-1:0]    all_ps,
    output logic                                 found,
    output tlb_entry_pkg::tlb_idx_t              hit_index,
    output tlb_entry_pkg::vpn_t                  req_vpn,
    output tlb_access_pkg::plv_t                 req_plv,
    output tlb_access_pkg::mem_type_e            req_mem_type
);
    import tlb_entry_pkg::*;
    import tlb_access_pkg::*;

    asid_t               req_asid;
    vpn2_t               req_vpn2;
    logic [`TLB_NUM-1:0] hit;

    // request latch, held while en is low so the result stays put
    always_ff @(posedge clk) begin
        if (rst) begin
            req_vpn      <= `TLB_REQ_RST_VPN;
            req_asid     <= `TLB_REQ_RST_ASID;
            req_plv      <= `TLB_REQ_RST_PLV;
            req_mem_type <= MEM_FETCH;
        end else if (en) begin
            req_vpn      <= vpn;
            req_asid     <= asid;
            req_plv      <= plv;
            req_mem_type <= mem_type;
        end
    end

    assign req_vpn2 = req_vpn[19:1];

    // per-entry compare, 2M pages ignore the low 9 bits of vpn2
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            hit[i] = all_e[i] && (all_g[i] || all_asid[i] == req_asid);
            if (all_ps[i] == `TLB_PS_4K) begin
                hit[i] = hit[i] && (all_vpn2[i] == req_vpn2);
            end else if (all_ps[i] == `TLB_PS_2M) begin
                hit[i] = hit[i] && (all_vpn2[i][18:9] == req_vpn2[18:9]);
            end else begin
                hit[i] = 1'b0;
            end
        end
    end

    // lowest index wins
    always_comb begin
        hit_index = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_index = tlb_idx_t'(i);
            end
        end
    end

    assign found = |hit;

endmodule

// File: hw/tlb/tlb_page_select.sv
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_page_select (
    input  logic                                 found,
    input  tlb_entry_pkg::tlb_idx_t              hit_index,
    input  tlb_entry_pkg::vpn_t                  req_vpn,
    input  tlb_access_pkg::plv_t                 req_plv,
    input  tlb_access_pkg::mem_type_e            req_mem_type,
    input  tlb_entry_pkg::ps_t [`TLB_NUM-1:0]    all_ps,
    input  tlb_entry_pkg::pfn_t [`TLB_NUM-1:0]   all_pfn0,
    input  tlb_entry_pkg::mat_t [`TLB_NUM-1:0]   all_mat0,
    input  tlb_access_pkg::plv_t [`TLB_NUM-1:0]  all_plv0,
    input  logic [`TLB_NUM-1:0]                  all_d0,
    input  logic [`TLB_NUM-1:0]                  all_v0,
    input  tlb_entry_pkg::pfn_t [`TLB_NUM-1:0]   all_pfn1,
    input  tlb_entry_pkg::mat_t [`TLB_NUM-1:0]   all_mat1,
    input  tlb_access_pkg::plv_t [`TLB_NUM-1:0]  all_plv1,
    input  logic [`TLB_NUM-1:0]                  all_d1,
    input  logic [`TLB_NUM-1:0]                  all_v1,
    output tlb_entry_pkg::pfn_t                  pfn,
    output tlb_entry_pkg::mat_t                  mat,
    output tlb_access_pkg::exc_t                 exc
);
    import tlb_entry_pkg::*;
    import tlb_access_pkg::*;

    logic is_2m;
    logic odd;
    pfn_t pg_pfn;
    mat_t pg_mat;
    plv_t pg_plv;
    logic pg_d;
    logic pg_v;

    assign is_2m = (all_ps[hit_index] == `TLB_PS_2M);
    // odd page bit sits just above the page offset
    assign odd = is_2m ? req_vpn[9] : req_vpn[0];

    always_comb begin
        if (odd) begin
            pg_pfn = all_pfn1[hit_index];
            pg_mat = all_mat1[hit_index];
            pg_plv = all_plv1[hit_index];
            pg_d   = all_d1[hit_index];
            pg_v   = all_v1[hit_index];
        end else begin
            pg_pfn = all_pfn0[hit_index];
            pg_mat = all_mat0[hit_index];
            pg_plv = all_plv0[hit_index];
            pg_d   = all_d0[hit_index];
            pg_v   = all_v0[hit_index];
        end
    end

    // 2M frame keeps the low 9 vpn bits
    always_comb begin
        if (!found) begin
            pfn = '0;
        end else if (is_2m) begin
            pfn = {pg_pfn[19:9], req_vpn[8:0]};
        end else begin
            pfn = pg_pfn;
        end
    end

    assign mat = found ? pg_mat : '0;

    // prioritised exception
    always_comb begin
        if (!found) begin
            exc = EXC_REFILL;
        end else if (!pg_v) begin
            case (req_mem_type)
                MEM_FETCH: exc = EXC_PIF;
                MEM_STORE: exc = EXC_PIS;
                default:   exc = EXC_PIL;
            endcase
        end else if (req_plv > pg_plv) begin
            exc = EXC_PPI;
        end else if (req_mem_type == MEM_STORE && !pg_d) begin
            exc = EXC_PME;
        end else begin
            exc = EXC_NONE;
        end
    end

endmodule

// File: hw/tlb/tlb.sv
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb (
    input  logic                       clk,
    input  logic                       rst,
    // fetch port
    input  tlb_entry_pkg::vpn_t        s0_vpn,
    input  tlb_entry_pkg::asid_t       s0_asid,
    input  tlb_access_pkg::plv_t       s0_plv,
    input  tlb_access_pkg::mem_type_e  s0_mem_type,
    input  logic                       s0_en,
    output logic                       s0_found,
    output tlb_entry_pkg::pfn_t        s0_pfn,
    output tlb_entry_pkg::mat_t        s0_mat,
    output tlb_access_pkg::exc_t       s0_exception,
    // data port
    input  tlb_entry_pkg::vpn_t        s1_vpn,
    input  tlb_entry_pkg::asid_t       s1_asid,
    input  tlb_access_pkg::plv_t       s1_plv,
    input  tlb_access_pkg::mem_type_e  s1_mem_type,
    input  logic                       s1_en,
    output logic                       s1_found,
    output tlb_entry_pkg::pfn_t        s1_pfn,
    output tlb_entry_pkg::mat_t        s1_mat,
    output tlb_access_pkg::exc_t       s1_exception,
    // write port
    input  logic                       we,
    input  tlb_entry_pkg::tlb_idx_t    w_index,
    input  tlb_entry_pkg::vpn2_t       w_vpn2,
    input  tlb_entry_pkg::asid_t       w_asid,
    input  tlb_entry_pkg::ps_t         w_ps,
    input  logic                       w_e,
    input  logic                       w_g,
    input  tlb_entry_pkg::pfn_t        w_pfn0,
    input  tlb_entry_pkg::mat_t        w_mat0,
    input  tlb_access_pkg::plv_t       w_plv0,
    input  logic                       w_d0,
    input  logic                       w_v0,
    input  tlb_entry_pkg::pfn_t        w_pfn1,
    input  tlb_entry_pkg::mat_t        w_mat1,
    input  tlb_access_pkg::plv_t       w_plv1,
    input  logic                       w_d1,
    input  logic                       w_v1,
    // read port
    input  tlb_entry_pkg::tlb_idx_t    r_index,
    output tlb_entry_pkg::vpn2_t       r_vpn2,
    output tlb_entry_pkg::asid_t       r_asid,
    output tlb_entry_pkg::ps_t         r_ps,
    output logic                       r_e,
    output logic                       r_g,
    output tlb_entry_pkg::pfn_t        r_pfn0,
    output tlb_entry_pkg::mat_t        r_mat0,
    output tlb_access_pkg::plv_t       r_plv0,
    output logic                       r_d0,
    output logic                       r_v0,
    output tlb_entry_pkg::pfn_t        r_pfn1,
    output tlb_entry_pkg::mat_t        r_mat1,
    output tlb_access_pkg::plv_t       r_plv1,
    output logic                       r_d1,
    output logic                       r_v1
);
    import tlb_entry_pkg::*;
    import tlb_access_pkg::*;

    logic [`TLB_NUM-1:0]  all_e;
    logic [`TLB_NUM-1:0]  all_g;
    asid_t [`TLB_NUM-1:0] all_asid;
    vpn2_t [`TLB_NUM-1:0] all_vpn2;
    ps_t [`TLB_NUM-1:0]   all_ps;
    pfn_t [`TLB_NUM-1:0]  all_pfn0;
    mat_t [`TLB_NUM-1:0]  all_mat0;
    plv_t [`TLB_NUM-1:0]  all_plv0;
    logic [`TLB_NUM-1:0]  all_d0;
    logic [`TLB_NUM-1:0]  all_v0;
    pfn_t [`TLB_NUM-1:0]  all_pfn1;
    mat_t [`TLB_NUM-1:0]  all_mat1;
    plv_t [`TLB_NUM-1:0]  all_plv1;
    logic [`TLB_NUM-1:0]  all_d1;
    logic [`TLB_NUM-1:0]  all_v1;

    // match stage to result stage
    tlb_idx_t  s0_hit_index, s1_hit_index;
    vpn_t      s0_req_vpn, s1_req_vpn;
    plv_t      s0_req_plv, s1_req_plv;
    mem_type_e s0_req_mem_type, s1_req_mem_type;

    // port names line up with the storage one to one
    tlb_entries entries (.*);

    tlb_match match0 (
        .en           (s0_en),
        .vpn          (s0_vpn),
        .asid         (s0_asid),
        .plv          (s0_plv),
        .mem_type     (s0_mem_type),
        .found        (s0_found),
        .hit_index    (s0_hit_index),
        .req_vpn      (s0_req_vpn),
        .req_plv      (s0_req_plv),
        .req_mem_type (s0_req_mem_type),
        .*
    );

    tlb_match match1 (
        .en           (s1_en),
        .vpn          (s1_vpn),
        .asid         (s1_asid),
        .plv          (s1_plv),
        .mem_type     (s1_mem_type),
        .found        (s1_found),
        .hit_index    (s1_hit_index),
        .req_vpn      (s1_req_vpn),
        .req_plv      (s1_req_plv),
        .req_mem_type (s1_req_mem_type),
        .*
    );

    tlb_page_select select0 (
        .found        (s0_found),
        .hit_index    (s0_hit_index),
        .req_vpn      (s0_req_vpn),
        .req_plv      (s0_req_plv),
        .req_mem_type (s0_req_mem_type),
        .pfn          (s0_pfn),
        .mat          (s0_mat),
        .exc          (s0_exception),
        .*
    );

    tlb_page_select select1 (
        .found        (s1_found),
        .hit_index    (s1_hit_index),
        .req_vpn      (s1_req_vpn),
        .req_plv      (s1_req_plv),
        .req_mem_type (s1_req_mem_type),
        .pfn          (s1_pfn),
        .mat          (s1_mat),
        .exc          (s1_exception),
        .*
    );

endmodule

// File: dv/tlb_clkgen.sv
`timescale 1ns/1ps

module tlb_clkgen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held over the first 8 rising edges
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: dv/tlb_asserts.sv
`timescale 1ns/1ps

module tlb_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 s0_found,
    input logic                 s1_found,
    input tlb_entry_pkg::pfn_t  s0_pfn,
    input tlb_entry_pkg::pfn_t  s1_pfn,
    input tlb_access_pkg::exc_t s0_exception,
    input tlb_access_pkg::exc_t s1_exception
);
    import tlb_access_pkg::*;

    int fail_count = 0;

    // at most one exception bit
    a_s0_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(s0_exception))
        else begin fail_count++; $error("s0 exception code has more than one bit set"); end
    a_s1_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(s1_exception))
        else begin fail_count++; $error("s1 exception code has more than one bit set"); end

    // a miss always reports refill with a zero frame
    a_s0_refill: assert property (@(posedge clk) disable iff (rst)
            !s0_found |-> s0_exception == EXC_REFILL)
        else begin fail_count++; $error("s0 miss without refill code"); end
    a_s1_refill: assert property (@(posedge clk) disable iff (rst)
            !s1_found |-> s1_exception == EXC_REFILL)
        else begin fail_count++; $error("s1 miss without refill code"); end
    a_s0_pfn: assert property (@(posedge clk) disable iff (rst) !s0_found |-> s0_pfn == '0)
        else begin fail_count++; $error("s0 miss with nonzero pfn"); end
    a_s1_pfn: assert property (@(posedge clk) disable iff (rst) !s1_found |-> s1_pfn == '0)
        else begin fail_count++; $error("s1 miss with nonzero pfn"); end

endmodule

bind tlb tlb_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .s0_found     (s0_found),
    .s1_found     (s1_found),
    .s0_pfn       (s0_pfn),
    .s1_pfn       (s1_pfn),
    .s0_exception (s0_exception),
    .s1_exception (s1_exception)
);

// File: dv/tlb_tb.sv
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_tb;
    import tlb_entry_pkg::*;
    import tlb_access_pkg::*;

    localparam int TIMEOUT = 50;

    logic      clk, rst;
    vpn_t      s0_vpn, s1_vpn;
    asid_t     s0_asid, s1_asid;
    plv_t      s0_plv, s1_plv;
    mem_type_e s0_mem_type, s1_mem_type;
    logic      s0_en, s1_en, s0_found, s1_found;
    pfn_t      s0_pfn, s1_pfn;
    mat_t      s0_mat, s1_mat;
    exc_t      s0_exception, s1_exception;
    logic      we;
    tlb_idx_t  w_index, r_index;
    vpn2_t     w_vpn2, r_vpn2;
    asid_t     w_asid, r_asid;
    ps_t       w_ps, r_ps;
    logic      w_e, w_g, w_d0, w_v0, w_d1, w_v1;
    logic      r_e, r_g, r_d0, r_v0, r_d1, r_v1;
    pfn_t      w_pfn0, w_pfn1, r_pfn0, r_pfn1;
    mat_t      w_mat0, w_mat1, r_mat0, r_mat1;
    plv_t      w_plv0, w_plv1, r_plv0, r_plv1;

    // reference entries with page 0 even and page 1 odd
    logic  m_e [`TLB_NUM];
    logic  m_g [`TLB_NUM];
    asid_t m_asid [`TLB_NUM];
    vpn2_t m_vpn2 [`TLB_NUM];
    ps_t   m_ps [`TLB_NUM];
    pfn_t  m_pfn [`TLB_NUM][2];
    mat_t  m_mat [`TLB_NUM][2];
    plv_t  m_plv [`TLB_NUM][2];
    logic  m_d [`TLB_NUM][2];
    logic  m_v [`TLB_NUM][2];

    // request each port holds
    vpn_t      l_vpn [2];
    asid_t     l_asid [2];
    plv_t      l_plv [2];
    mem_type_e l_mt [2];

    logic [31:0] lcg_state = 32'd62421;

    tlb_clkgen clk_rst (.clk(clk), .rst(rst));

    tlb i_tlb (.*);

    function automatic logic [23:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:8];
    endfunction

    // small pool so that entries and lookups collide often
    function automatic vpn2_t pick_vpn2();
        logic [23:0] r;
        r = lcg_next();
        return {8'h0, r[1:0], r[2], 6'h0, r[4:3]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_found(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %0b got %0b", $time, name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_pfn(input string name, input pfn_t exp, input pfn_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_mat(input string name, input mat_t exp, input mat_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_exc(input string name, input exc_t exp, input exc_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_read(input string name, input vpn2_t exp, input vpn2_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_asid(input string name, input asid_t exp, input asid_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_ps(input string name, input ps_t exp, input ps_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_plv(input string name, input plv_t exp, input plv_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic model_lookup(input vpn_t vpn, input asid_t asid, input plv_t plv,
            input mem_type_e mt, output logic f, output pfn_t pfn, output mat_t mat,
            output exc_t exc);
        int   idx;
        logic odd;
        logic big;
        logic same;
        idx = -1;
        for (int i = 0; i < `TLB_NUM; i++) begin
            big = (m_ps[i] == `TLB_PS_2M);
            same = big ? (m_vpn2[i][18:9] == vpn[19:10]) : (m_vpn2[i] == vpn[19:1]);
            if (idx < 0 && m_e[i] && (m_g[i] || m_asid[i] == asid) && same) begin
                idx = i;
            end
        end
        f = (idx >= 0);
        pfn = '0;
        mat = '0;
        exc = EXC_REFILL;
        if (f) begin
            big = (m_ps[idx] == `TLB_PS_2M);
            odd = big ? vpn[9] : vpn[0];
            pfn = m_pfn[idx][odd];
            if (big) begin
                pfn[8:0] = vpn[8:0];
            end
            mat = m_mat[idx][odd];
            if (!m_v[idx][odd]) begin
                exc = (mt == MEM_FETCH) ? EXC_PIF : (mt == MEM_LOAD) ? EXC_PIL : EXC_PIS;
            end else if (plv > m_plv[idx][odd]) begin
                exc = EXC_PPI;
            end else if (mt == MEM_STORE && !m_d[idx][odd]) begin
                exc = EXC_PME;
            end else begin
                exc = EXC_NONE;
            end
        end
    endtask

    task automatic check_port(input int p, input logic found, input pfn_t pfn,
            input mat_t mat, input exc_t exc);
        logic e_found;
        pfn_t e_pfn;
        mat_t e_mat;
        exc_t e_exc;
        model_lookup(l_vpn[p], l_asid[p], l_plv[p], l_mt[p], e_found, e_pfn, e_mat, e_exc);
        check_found($sformatf("s%0d_found", p), e_found, found);
        check_pfn($sformatf("s%0d_pfn", p), e_pfn, pfn);
        check_mat($sformatf("s%0d_mat", p), e_mat, mat);
        check_exc($sformatf("s%0d_exception", p), e_exc, exc);
    endtask

    task automatic random_write(input tlb_idx_t idx);
        logic [23:0] r;
        r = lcg_next();
        we      = 1'b1;
        w_index = idx;
        w_vpn2  = pick_vpn2();
        w_asid  = {6'b0, r[1:0]};
        w_g     = (r[3:2] == 2'b00);
        w_e     = (r[6:4] != 3'b000);
        w_ps    = r[7] ? `TLB_PS_2M : `TLB_PS_4K;
        w_mat0  = r[9:8];
        w_plv0  = r[11:10];
        w_d0    = r[12];
        w_v0    = (r[14:13] != 2'b00);
        w_mat1  = r[16:15];
        w_plv1  = r[18:17];
        w_d1    = r[19];
        w_v1    = (r[21:20] != 2'b00);
        r = lcg_next();
        w_pfn0  = r[19:0];
        r = lcg_next();
        w_pfn1  = r[19:0];
        m_e[idx]    = w_e;
        m_g[idx]    = w_g;
        m_asid[idx] = w_asid;
        m_vpn2[idx] = w_vpn2;
        m_ps[idx]   = w_ps;
        m_pfn[idx]  = '{w_pfn0, w_pfn1};
        m_mat[idx]  = '{w_mat0, w_mat1};
        m_plv[idx]  = '{w_plv0, w_plv1};
        m_d[idx]    = '{w_d0, w_d1};
        m_v[idx]    = '{w_v0, w_v1};
    endtask

    task automatic random_request(output vpn_t vpn, output asid_t asid, output plv_t plv,
            output mem_type_e mt);
        logic [23:0] r;
        r = lcg_next();
        vpn  = {pick_vpn2(), r[0]};
        asid = {6'b0, r[2:1]};
        plv  = r[4:3];
        mt   = (r[6:5] == 2'b11) ? MEM_STORE : mem_type_e'(r[6:5]);
    endtask

    task automatic wait_reset_done();
        for (int t = 0; rst !== 1'b0; t++) begin
            if (t >= TIMEOUT) begin
                abort_run("reset was never released");
            end
            @(posedge clk);
        end
        #1;
    endtask

    initial begin
        logic [23:0] r;
        logic        hold;
        {s0_vpn, s0_asid, s0_plv, s0_en} = '0;
        {s1_vpn, s1_asid, s1_plv, s1_en} = '0;
        s0_mem_type = MEM_FETCH;
        s1_mem_type = MEM_FETCH;
        {we, w_index, w_vpn2, w_asid, w_ps, w_e, w_g} = '0;
        {w_pfn0, w_mat0, w_plv0, w_d0, w_v0} = '0;
        {w_pfn1, w_mat1, w_plv1, w_d1, w_v1} = '0;
        r_index = '0;
        for (int p = 0; p < 2; p++) begin
            l_vpn[p] = '0;
            l_asid[p] = '0;
            l_plv[p] = '0;
            l_mt[p] = MEM_FETCH;
        end
        for (int i = 0; i < `TLB_NUM; i++) begin
            m_e[i] = 1'b0;
        end
        wait_reset_done();

        // reset state
        #2;
        check_port(0, s0_found, s0_pfn, s0_mat, s0_exception);
        check_port(1, s1_found, s1_pfn, s1_mat, s1_exception);
        for (int i = 0; i < `TLB_NUM; i++) begin
            next_edge();
            r_index = tlb_idx_t'(i);
            #2;
            check_found("r_e", 1'b0, r_e);
        end

        // fill every entry and read it back
        for (int i = 0; i < `TLB_NUM; i++) begin
            next_edge();
            random_write(tlb_idx_t'(i));
            next_edge();
            we = 1'b0;
            r_index = tlb_idx_t'(i);
            #2;
            check_read("r_vpn2", m_vpn2[i], r_vpn2);
            check_asid("r_asid", m_asid[i], r_asid);
            check_ps("r_ps", m_ps[i], r_ps);
            check_found("r_e", m_e[i], r_e);
            check_found("r_g", m_g[i], r_g);
            check_found("r_d0", m_d[i][0], r_d0);
            check_found("r_v0", m_v[i][0], r_v0);
            check_found("r_d1", m_d[i][1], r_d1);
            check_found("r_v1", m_v[i][1], r_v1);
            check_pfn("r_pfn0", m_pfn[i][0], r_pfn0);
            check_pfn("r_pfn1", m_pfn[i][1], r_pfn1);
            check_mat("r_mat0", m_mat[i][0], r_mat0);
            check_mat("r_mat1", m_mat[i][1], r_mat1);
            check_plv("r_plv0", m_plv[i][0], r_plv0);
            check_plv("r_plv1", m_plv[i][1], r_plv1);
        end

        // random lookups with some writes on the latching edge and some holds
        for (int n = 0; n < 400; n++) begin
            next_edge();
            r = lcg_next();
            hold = (r[1:0] == 2'b00);
            if (!hold && r[3:2] == 2'b00) begin
                random_write(tlb_idx_t'(r[11:4]));
            end
            random_request(s0_vpn, s0_asid, s0_plv, s0_mem_type);
            random_request(s1_vpn, s1_asid, s1_plv, s1_mem_type);
            s0_en = !hold;
            s1_en = !hold;
            if (!hold) begin
                l_vpn = '{s0_vpn, s1_vpn};
                l_asid = '{s0_asid, s1_asid};
                l_plv = '{s0_plv, s1_plv};
                l_mt = '{s0_mem_type, s1_mem_type};
            end
            next_edge();
            we = 1'b0;
            s0_en = 1'b0;
            s1_en = 1'b0;
            #2;
            check_port(0, s0_found, s0_pfn, s0_mat, s0_exception);
            check_port(1, s1_found, s1_pfn, s1_mat, s1_exception);
        end

        next_edge();
        if (i_tlb.u_asserts.fail_count != 0) begin
            abort_run("a bound assertion failed during the run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: tlb.f
+incdir+common
common/tlb_entry_pkg.sv
common/tlb_access_pkg.sv
hw/tlb/tlb_entries.sv
hw/tlb/tlb_match.sv
hw/tlb/tlb_page_select.sv
hw/tlb/tlb.sv
dv/tlb_clkgen.sv
dv/tlb_asserts.sv
dv/tlb_tb.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat tlb.f)) common/tlb_settings.svh

.PHONY: run clean

run: obj_dir/Vtlb_tb
	@out="$$(./obj_dir/Vtlb_tb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

obj_dir/Vtlb_tb: tlb.f $(SRCS)
	verilator --binary --timing --assert --top-module tlb_tb -f tlb.f -o Vtlb_tb

clean:
	rm -rf obj_dir
